// ==== hdl/hub_settings.svh ====
`ifndef HUB_SETTINGS_SVH
`define HUB_SETTINGS_SVH

// message format
`define HUB_MSG_WIDTH 32
`define HUB_FPGA_ID_WIDTH 4
`define HUB_FIFO_ID_WIDTH 4

// link geometry
`define HUB_DOWN_PORTS 2
`define HUB_UP_BEAT 16
`define HUB_DOWN_BEAT 8

// input buffering per link
`define HUB_FIFO_DEPTH 8

// fifo id reserved for the stage controller
`define HUB_CTRL_FIFO_ID 15

// routing table bounds
// id 0 goes upstream, 1..7 to downstream 0, the rest to downstream 1
`define HUB_DOWN0_LAST_ID 7

`endif

// ==== hdl/hub_msg_pkg.sv ====
`include "hub_settings.svh"

package hub_msg_pkg;

    localparam int PAYLOAD_WIDTH = `HUB_MSG_WIDTH - `HUB_FPGA_ID_WIDTH - `HUB_FIFO_ID_WIDTH;

    // destination fpga id sits in the top bits
    typedef struct packed {
        logic [`HUB_FPGA_ID_WIDTH-1:0] dest_fpga;
        logic [`HUB_FIFO_ID_WIDTH-1:0] fifo_id;
        logic [PAYLOAD_WIDTH-1:0]      payload;
    } hub_msg_t;

    // one bit per output link, the top bit is upstream
    typedef logic [`HUB_DOWN_PORTS:0] route_mask_t;

    // downstream ports by index, upstream above them
    typedef logic [1:0] src_sel_t;

    localparam src_sel_t SRC_UP = 2'd2;

endpackage

// ==== hdl/hub_link_pkg.sv ====
`include "hub_settings.svh"

package hub_link_pkg;

    typedef logic [`HUB_UP_BEAT-1:0] up_beat_t;
    typedef logic [`HUB_DOWN_BEAT-1:0] down_beat_t;

    // flags reported to the parent node
    typedef struct packed {
        logic message_flying;
        logic odd_clusters;
    } up_status_t;

    // same flags, one bit per child
    typedef struct packed {
        logic [`HUB_DOWN_PORTS-1:0] message_flying;
        logic [`HUB_DOWN_PORTS-1:0] odd_clusters;
    } down_status_t;

    typedef logic [1:0] stage_state_t;

endpackage

// ==== hdl/link_fifo.sv ====
`timescale 1ns/1ps

module link_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int DEPTH = 8
) (
    input  logic   clk,
    input  logic   reset,
    input  entry_t in_data,
    input  logic   in_valid,
    output logic   in_ready,
    output entry_t out_data,
    output logic   out_valid,
    input  logic   out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_write;
    logic             do_read;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign in_ready  = !full;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign do_write  = in_valid && in_ready;
    assign do_read   = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a write refused while full stays offered unchanged
    a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        (in_valid && full) |=> (in_valid && $stable(in_data)));

endmodule

// ==== hdl/link_deserializer.sv ====
`timescale 1ns/1ps

module link_deserializer #(
    parameter type beat_t = logic [7:0]
) (
    input  logic                  clk,
    input  logic                  reset,
    input  beat_t                 beat,
    input  logic                  beat_valid,
    output logic                  beat_ready,
    output hub_msg_pkg::hub_msg_t msg,
    output logic                  msg_valid,
    input  logic                  msg_ready
);

    localparam int MSG_W  = $bits(hub_msg_pkg::hub_msg_t);
    localparam int BEAT_W = $bits(beat_t);
    localparam int BEATS  = MSG_W / BEAT_W;
    localparam int CNT_W  = (BEATS > 1) ? $clog2(BEATS) : 1;

    logic [MSG_W-1:0] shift_q;
    logic [CNT_W-1:0] count;
    logic             take;

    // hold off new beats while a finished message waits
    assign beat_ready = !msg_valid;
    assign take       = beat_valid && beat_ready;
    assign msg        = hub_msg_pkg::hub_msg_t'(shift_q);

    // first beat ends up in the top bits
    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= (shift_q << BEAT_W) | MSG_W'(beat);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= '0;
            msg_valid <= 1'b0;
        end else begin
            if (take) begin
                if (count == CNT_W'(BEATS - 1)) begin
                    count     <= '0;
                    msg_valid <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end else if (msg_valid && msg_ready) begin
                msg_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/link_serializer.sv ====
`timescale 1ns/1ps

module link_serializer #(
    parameter type beat_t = logic [7:0]
) (
    input  logic                  clk,
    input  logic                  reset,
    input  hub_msg_pkg::hub_msg_t msg,
    input  logic                  msg_valid,
    output logic                  msg_ready,
    output beat_t                 beat,
    output logic                  beat_valid,
    input  logic                  beat_ready
);

    localparam int MSG_W  = $bits(hub_msg_pkg::hub_msg_t);
    localparam int BEAT_W = $bits(beat_t);
    localparam int BEATS  = MSG_W / BEAT_W;
    localparam int CNT_W  = (BEATS > 1) ? $clog2(BEATS) : 1;

    logic [MSG_W-1:0] shift_q;
    logic [CNT_W-1:0] count;
    logic             busy;
    logic             load;
    logic             sent;

    assign msg_ready  = !busy;
    assign load       = msg_valid && msg_ready;
    assign beat_valid = busy;
    assign sent       = beat_valid && beat_ready;
    // most significant beat leaves first
    assign beat       = beat_t'(shift_q[MSG_W-1 -: BEAT_W]);

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= MSG_W'(msg);
        end else if (sent) begin
            shift_q <= shift_q << BEAT_W;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else begin
            if (load) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (sent) begin
                if (count == CNT_W'(BEATS - 1)) begin
                    busy <= 1'b0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // link rule, a pending beat stays put until the far side takes it
    a_beat_held: assert property (@(posedge clk) disable iff (reset)
        (beat_valid && !beat_ready) |=> (beat_valid && $stable(beat)));

endmodule

// ==== hdl/hub_arbiter.sv ====
`timescale 1ns/1ps
`include "hub_settings.svh"

module hub_arbiter (
    input  logic                                         clk,
    input  logic                                         reset,
    input  hub_msg_pkg::hub_msg_t                        up_msg,
    input  logic                                         up_valid,
    output logic                                         up_ready,
    input  hub_msg_pkg::hub_msg_t [`HUB_DOWN_PORTS-1:0] down_msg,
    input  logic [`HUB_DOWN_PORTS-1:0]                   down_valid,
    output logic [`HUB_DOWN_PORTS-1:0]                   down_ready,
    input  logic                                         advance,
    output hub_msg_pkg::hub_msg_t                        sel_msg,
    output hub_msg_pkg::src_sel_t                        sel_src,
    output logic                                         sel_valid
);

    logic [`HUB_DOWN_PORTS-1:0] down_grant;
    logic                       down_any;
    hub_msg_pkg::hub_msg_t      down_pick_msg;
    hub_msg_pkg::src_sel_t      down_pick_src;

    // lowest valid downstream index wins
    always_comb begin
        down_grant    = '0;
        down_any      = 1'b0;
        down_pick_msg = down_msg[0];
        down_pick_src = '0;
        for (int i = 0; i < `HUB_DOWN_PORTS; i++) begin
            if (down_valid[i] && !down_any) begin
                down_grant[i] = 1'b1;
                down_any      = 1'b1;
                down_pick_msg = down_msg[i];
                down_pick_src = hub_msg_pkg::src_sel_t'(i);
            end
        end
    end

    // upstream beats every child
    assign up_ready   = advance && up_valid;
    assign down_ready = (advance && !up_valid) ? down_grant : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_valid <= 1'b0;
        end else if (advance) begin
            sel_valid <= up_valid || down_any;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (up_valid) begin
                sel_msg <= up_msg;
                sel_src <= hub_msg_pkg::SRC_UP;
            end else begin
                sel_msg <= down_pick_msg;
                sel_src <= down_pick_src;
            end
        end
    end

    a_single_take: assert property (@(posedge clk) disable iff (reset)
        $onehot0({up_valid && up_ready, down_valid & down_ready}));

endmodule

// ==== hdl/hub_router.sv ====
`timescale 1ns/1ps
`include "hub_settings.svh"

module hub_router (
    input  logic                       clk,
    input  logic                       reset,
    input  hub_msg_pkg::hub_msg_t      sel_msg,
    input  hub_msg_pkg::src_sel_t      sel_src,
    input  logic                       sel_valid,
    output logic                       advance,
    output hub_msg_pkg::hub_msg_t      out_msg,
    output hub_msg_pkg::route_mask_t   out_route,
    input  hub_msg_pkg::route_mask_t   out_ready,
    input  hub_link_pkg::down_status_t down_status,
    input  hub_link_pkg::stage_state_t up_state,
    output hub_link_pkg::up_status_t   up_status,
    output hub_link_pkg::stage_state_t down_state
);

    localparam int UP_BIT = `HUB_DOWN_PORTS;
    localparam logic [`HUB_FIFO_ID_WIDTH-1:0] CTRL_ID    = `HUB_CTRL_FIFO_ID;
    localparam logic [`HUB_FPGA_ID_WIDTH-1:0] DOWN0_LAST = `HUB_DOWN0_LAST_ID;

    logic                     is_ctrl;
    logic                     from_up;
    hub_msg_pkg::route_mask_t table_route;
    hub_msg_pkg::route_mask_t next_route;
    hub_msg_pkg::route_mask_t route_q;

    assign is_ctrl = (sel_msg.fifo_id == CTRL_ID);
    assign from_up = (sel_src == hub_msg_pkg::SRC_UP);

    // move on only when every serializer can accept
    assign advance   = &out_ready;
    assign out_route = advance ? route_q : '0;

    // fpga id table
    always_comb begin
        table_route = '0;
        if (sel_msg.dest_fpga == '0) begin
            table_route[UP_BIT] = 1'b1;
        end else if (sel_msg.dest_fpga <= DOWN0_LAST) begin
            table_route[0] = 1'b1;
        end else begin
            table_route[1] = 1'b1;
        end
    end

    always_comb begin
        next_route = '0;
        if (sel_valid) begin
            if (is_ctrl && from_up) begin
                // controller broadcast to all children
                next_route[UP_BIT-1:0] = '1;
            end else if (is_ctrl) begin
                next_route[UP_BIT] = 1'b1;
            end else begin
                next_route = table_route;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            route_q <= '0;
        end else if (advance) begin
            route_q <= next_route;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_msg <= sel_msg;
        end
    end

    // cluster status relay, one register stage each way
    always_ff @(posedge clk) begin
        if (reset) begin
            up_status  <= '0;
            down_state <= '0;
        end else begin
            up_status.message_flying <= |down_status.message_flying;
            up_status.odd_clusters   <= |down_status.odd_clusters;
            down_state               <= up_state;
        end
    end

endmodule

// ==== hdl/hub_top.sv ====
`timescale 1ns/1ps
`include "hub_settings.svh"

module hub_top (
    input  logic                                           clk,
    input  logic                                           reset,
    input  hub_link_pkg::up_beat_t                         up_in_beat,
    input  logic                                           up_in_valid,
    output logic                                           up_in_ready,
    output hub_link_pkg::up_beat_t                         up_out_beat,
    output logic                                           up_out_valid,
    input  logic                                           up_out_ready,
    input  hub_link_pkg::down_beat_t [`HUB_DOWN_PORTS-1:0] down_in_beat,
    input  logic [`HUB_DOWN_PORTS-1:0]                     down_in_valid,
    output logic [`HUB_DOWN_PORTS-1:0]                     down_in_ready,
    output hub_link_pkg::down_beat_t [`HUB_DOWN_PORTS-1:0] down_out_beat,
    output logic [`HUB_DOWN_PORTS-1:0]                     down_out_valid,
    input  logic [`HUB_DOWN_PORTS-1:0]                     down_out_ready,
    input  hub_link_pkg::down_status_t                     down_status,
    input  hub_link_pkg::stage_state_t                     up_state,
    output hub_link_pkg::up_status_t                       up_status,
    output hub_link_pkg::stage_state_t                     down_state
);

    localparam int UP_BIT = `HUB_DOWN_PORTS;

    hub_link_pkg::up_beat_t                         up_fifo_beat;
    logic                                           up_fifo_valid;
    logic                                           up_fifo_ready;
    hub_msg_pkg::hub_msg_t                          up_msg;
    logic                                           up_msg_valid;
    logic                                           up_msg_ready;
    hub_link_pkg::down_beat_t [`HUB_DOWN_PORTS-1:0] down_fifo_beat;
    logic [`HUB_DOWN_PORTS-1:0]                     down_fifo_valid;
    logic [`HUB_DOWN_PORTS-1:0]                     down_fifo_ready;
    hub_msg_pkg::hub_msg_t [`HUB_DOWN_PORTS-1:0]    down_msg;
    logic [`HUB_DOWN_PORTS-1:0]                     down_msg_valid;
    logic [`HUB_DOWN_PORTS-1:0]                     down_msg_ready;
    hub_msg_pkg::hub_msg_t                          sel_msg;
    hub_msg_pkg::src_sel_t                          sel_src;
    logic                                           sel_valid;
    logic                                           advance;
    hub_msg_pkg::hub_msg_t                          out_msg;
    hub_msg_pkg::route_mask_t                       out_route;
    hub_msg_pkg::route_mask_t                       ser_ready;

    // upstream input path
    link_fifo #(.entry_t(hub_link_pkg::up_beat_t), .DEPTH(`HUB_FIFO_DEPTH)) up_fifo (
        .clk(clk), .reset(reset),
        .in_data(up_in_beat), .in_valid(up_in_valid), .in_ready(up_in_ready),
        .out_data(up_fifo_beat), .out_valid(up_fifo_valid), .out_ready(up_fifo_ready)
    );

    link_deserializer #(.beat_t(hub_link_pkg::up_beat_t)) up_deser (
        .clk(clk), .reset(reset),
        .beat(up_fifo_beat), .beat_valid(up_fifo_valid), .beat_ready(up_fifo_ready),
        .msg(up_msg), .msg_valid(up_msg_valid), .msg_ready(up_msg_ready)
    );

    // downstream input and output paths
    for (genvar i = 0; i < `HUB_DOWN_PORTS; i++) begin : g_down
        link_fifo #(.entry_t(hub_link_pkg::down_beat_t), .DEPTH(`HUB_FIFO_DEPTH)) fifo (
            .clk(clk), .reset(reset),
            .in_data(down_in_beat[i]), .in_valid(down_in_valid[i]),
            .in_ready(down_in_ready[i]),
            .out_data(down_fifo_beat[i]), .out_valid(down_fifo_valid[i]),
            .out_ready(down_fifo_ready[i])
        );

        link_deserializer #(.beat_t(hub_link_pkg::down_beat_t)) deser (
            .clk(clk), .reset(reset),
            .beat(down_fifo_beat[i]), .beat_valid(down_fifo_valid[i]),
            .beat_ready(down_fifo_ready[i]),
            .msg(down_msg[i]), .msg_valid(down_msg_valid[i]), .msg_ready(down_msg_ready[i])
        );

        link_serializer #(.beat_t(hub_link_pkg::down_beat_t)) ser (
            .clk(clk), .reset(reset),
            .msg(out_msg), .msg_valid(out_route[i]), .msg_ready(ser_ready[i]),
            .beat(down_out_beat[i]), .beat_valid(down_out_valid[i]),
            .beat_ready(down_out_ready[i])
        );
    end

    hub_arbiter arbiter (
        .clk(clk), .reset(reset),
        .up_msg(up_msg), .up_valid(up_msg_valid), .up_ready(up_msg_ready),
        .down_msg(down_msg), .down_valid(down_msg_valid), .down_ready(down_msg_ready),
        .advance(advance),
        .sel_msg(sel_msg), .sel_src(sel_src), .sel_valid(sel_valid)
    );

    hub_router router (
        .clk(clk), .reset(reset),
        .sel_msg(sel_msg), .sel_src(sel_src), .sel_valid(sel_valid),
        .advance(advance),
        .out_msg(out_msg), .out_route(out_route), .out_ready(ser_ready),
        .down_status(down_status), .up_state(up_state),
        .up_status(up_status), .down_state(down_state)
    );

    // upstream output path
    link_serializer #(.beat_t(hub_link_pkg::up_beat_t)) up_ser (
        .clk(clk), .reset(reset),
        .msg(out_msg), .msg_valid(out_route[UP_BIT]), .msg_ready(ser_ready[UP_BIT]),
        .beat(up_out_beat), .beat_valid(up_out_valid), .beat_ready(up_out_ready)
    );

endmodule

// ==== tb/hub_tb.sv ====
`timescale 1ns/1ps
`include "hub_settings.svh"

module hub_tb;

    localparam int NUM_CASES = 12;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * NUM_CASES;
    localparam int SRC_UP = 2;

    typedef struct packed {
        logic [1:0]  dest;
        logic [1:0]  src;
        logic [31:0] msg;
    } pending_t;

    logic                                           clk = 1'b0;
    logic                                           reset;
    hub_link_pkg::up_beat_t                         up_in_beat;
    logic                                           up_in_valid;
    logic                                           up_in_ready;
    hub_link_pkg::up_beat_t                         up_out_beat;
    logic                                           up_out_valid;
    logic                                           up_out_ready;
    hub_link_pkg::down_beat_t [`HUB_DOWN_PORTS-1:0] down_in_beat;
    logic [`HUB_DOWN_PORTS-1:0]                     down_in_valid;
    logic [`HUB_DOWN_PORTS-1:0]                     down_in_ready;
    hub_link_pkg::down_beat_t [`HUB_DOWN_PORTS-1:0] down_out_beat;
    logic [`HUB_DOWN_PORTS-1:0]                     down_out_valid;
    logic [`HUB_DOWN_PORTS-1:0]                     down_out_ready;
    hub_link_pkg::down_status_t                     down_status;
    hub_link_pkg::stage_state_t                     up_state;
    hub_link_pkg::up_status_t                       up_status;
    hub_link_pkg::stage_state_t                     down_state;

    logic [31:0]              stim_mem [3*NUM_CASES];
    pending_t                 pending [$];
    logic [31:0]              rnd;
    logic                     traffic_on;
    logic [31:0]              up_acc;
    int                       up_cnt;
    logic [31:0]              down_acc [`HUB_DOWN_PORTS];
    int                       down_cnt [`HUB_DOWN_PORTS];
    hub_link_pkg::up_status_t exp_status;
    int                       route_errors;
    int                       delivery_errors;
    int                       order_errors;
    int                       status_errors;
    int                       other_errors;

    hub_top DUT (
        .clk(clk), .reset(reset),
        .up_in_beat(up_in_beat), .up_in_valid(up_in_valid), .up_in_ready(up_in_ready),
        .up_out_beat(up_out_beat), .up_out_valid(up_out_valid), .up_out_ready(up_out_ready),
        .down_in_beat(down_in_beat), .down_in_valid(down_in_valid),
        .down_in_ready(down_in_ready),
        .down_out_beat(down_out_beat), .down_out_valid(down_out_valid),
        .down_out_ready(down_out_ready),
        .down_status(down_status), .up_state(up_state),
        .up_status(up_status), .down_state(down_state)
    );

    always #5 clk = !clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // destinations by the hub's routing rules
    function automatic logic [2:0] expected_route(input int src, input logic [31:0] word);
        hub_msg_pkg::hub_msg_t m;
        m = word;
        if (m.fifo_id == `HUB_CTRL_FIFO_ID) begin
            return (src == SRC_UP) ? 3'b011 : 3'b100;
        end
        if (m.dest_fpga == 0) begin
            return 3'b100;
        end
        if (m.dest_fpga <= `HUB_DOWN0_LAST_ID) begin
            return 3'b001;
        end
        return 3'b010;
    endfunction

    function automatic string link_name(input int link);
        if (link == SRC_UP) begin
            return "up";
        end
        return (link == 0) ? "down0" : "down1";
    endfunction

    task automatic send_msg(input int src, input logic [31:0] word);
        int   beats;
        logic accepted;
        beats = (src == SRC_UP) ? 2 : 4;
        for (int b = 0; b < beats; b++) begin
            if (src == SRC_UP) begin
                up_in_beat  = word[31-16*b -: 16];
                up_in_valid = 1'b1;
            end else begin
                down_in_beat[src]  = word[31-8*b -: 8];
                down_in_valid[src] = 1'b1;
            end
            // ready only moves on rising edges, so it is safe to look here
            do begin
                accepted = (src == SRC_UP) ? up_in_ready : down_in_ready[src];
                @(negedge clk);
            end while (!accepted);
        end
        if (src == SRC_UP) begin
            up_in_valid = 1'b0;
        end else begin
            down_in_valid[src] = 1'b0;
        end
    endtask

    task automatic send_from(input int src);
        for (int i = 0; i < NUM_CASES; i++) begin
            if (int'(stim_mem[3*i][1:0]) == src) begin
                repeat (i % 3) @(negedge clk);
                send_msg(src, stim_mem[3*i+1]);
            end
        end
    endtask

    task automatic check_arrival(input int dest, input logic [31:0] msg);
        int          hit;
        int          earlier;
        logic        have_head;
        logic [31:0] head;
        hit = -1;
        earlier = -1;
        have_head = 1'b0;
        head = '0;
        for (int k = 0; k < pending.size(); k++) begin
            if (pending[k].dest == dest) begin
                if (!have_head) begin
                    head = pending[k].msg;
                    have_head = 1'b1;
                end
                if (hit < 0 && pending[k].msg == msg) begin
                    hit = k;
                end
            end
        end
        for (int j = 0; j < hit; j++) begin
            if (pending[j].dest == dest && pending[j].src == pending[hit].src && earlier < 0) begin
                earlier = j;
            end
        end
        assert (hit >= 0) else begin
            delivery_errors++;
            if (have_head) begin
                $display("FAILED delivery to %s: expected %h actual %h",
                         link_name(dest), head, msg);
            end else begin
                $display("FAILED delivery to %s: expected none actual %h", link_name(dest), msg);
            end
        end
        if (hit >= 0) begin
            assert (earlier < 0) else begin
                order_errors++;
                $display("FAILED order to %s: expected %h actual %h",
                         link_name(dest), pending[earlier].msg, msg);
            end
            pending.delete(hit);
        end
    endtask

    // output sinks with random back-pressure, plus the status relay check
    always @(negedge clk) begin
        rnd = xorshift32(rnd);
        if (traffic_on) begin
            exp_status.message_flying = |down_status.message_flying;
            exp_status.odd_clusters = |down_status.odd_clusters;
            assert (up_status == exp_status) else begin
                status_errors++;
                $display("FAILED status up_status: expected %b actual %b", exp_status, up_status);
            end
            assert (down_state == up_state) else begin
                status_errors++;
                $display("FAILED status down_state: expected %b actual %b", up_state, down_state);
            end
        end
        up_out_ready = |rnd[1:0];
        down_out_ready[0] = |rnd[3:2];
        down_out_ready[1] = |rnd[5:4];
        if (up_out_valid && up_out_ready) begin
            up_acc = {up_acc[15:0], up_out_beat};
            up_cnt++;
            if (up_cnt == 2) begin
                up_cnt = 0;
                check_arrival(SRC_UP, up_acc);
            end
        end
        for (int i = 0; i < `HUB_DOWN_PORTS; i++) begin
            if (down_out_valid[i] && down_out_ready[i]) begin
                down_acc[i] = {down_acc[i][23:0], down_out_beat[i]};
                down_cnt[i]++;
                if (down_cnt[i] == 4) begin
                    down_cnt[i] = 0;
                    check_arrival(i, down_acc[i]);
                end
            end
        end
        if (rnd[10:8] == 3'd0) begin
            down_status = rnd[15:12];
            up_state = rnd[17:16];
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: %0d expected messages never arrived", pending.size());
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        int          src;
        logic [31:0] msg;
        logic [2:0]  calc;
        logic [2:0]  file_route;
        pending_t    entry;
        int          total;
        reset = 1'b1;
        up_in_beat = '0;
        up_in_valid = 1'b0;
        up_out_ready = 1'b0;
        down_in_beat = '0;
        down_in_valid = '0;
        down_out_ready = '0;
        down_status = '0;
        up_state = '0;
        rnd = 32'hca4ed992;
        traffic_on = 1'b0;
        up_acc = '0;
        up_cnt = 0;
        down_acc = '{default: '0};
        down_cnt = '{default: 0};
        route_errors = 0;
        delivery_errors = 0;
        order_errors = 0;
        status_errors = 0;
        other_errors = 0;

        $readmemh("tb/hub_stim.mem", stim_mem);
        assert (!$isunknown(stim_mem[3*NUM_CASES-1])) else begin
            other_errors++;
            $display("stimulus file tb/hub_stim.mem is missing or has too few cases");
        end

        // file routes against the rules, then the expected arrivals
        for (int i = 0; i < NUM_CASES; i++) begin
            src = stim_mem[3*i][1:0];
            msg = stim_mem[3*i+1];
            file_route = stim_mem[3*i+2][2:0];
            calc = expected_route(src, msg);
            assert (calc == file_route) else begin
                route_errors++;
                $display("FAILED route case %0d: expected %b actual %b", i, calc, file_route);
            end
            for (int d = 0; d < 3; d++) begin
                if (calc[d]) begin
                    entry.dest = d;
                    entry.src = src;
                    entry.msg = msg;
                    pending.push_back(entry);
                end
            end
        end

        repeat (RESET_CYCLES) @(negedge clk);
        assert ({up_out_valid, down_out_valid} == 3'b000) else begin
            other_errors++;
            $display("FAILED reset out_valid: expected 000 actual %b",
                     {up_out_valid, down_out_valid});
        end
        assert (up_status == '0 && down_state == '0) else begin
            other_errors++;
            $display("FAILED reset status: expected 0000 actual %b", {up_status, down_state});
        end
        assert ({up_in_ready, down_in_ready} == 3'b111) else begin
            other_errors++;
            $display("FAILED reset in_ready: expected 111 actual %b", {up_in_ready, down_in_ready});
        end
        reset = 1'b0;
        @(negedge clk);
        traffic_on = 1'b1;

        fork
            send_from(SRC_UP);
            send_from(0);
            send_from(1);
        join

        while (pending.size() != 0) begin
            @(negedge clk);
        end
        // quiet window to catch duplicates
        repeat (40) @(negedge clk);

        total = route_errors + delivery_errors + order_errors + status_errors + other_errors;
        $display("errors: route %0d, delivery %0d, order %0d, status %0d, other %0d",
                 route_errors, delivery_errors, order_errors, status_errors, other_errors);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/hub_msg_pkg.sv
hdl/hub_link_pkg.sv
hdl/link_fifo.sv
hdl/link_deserializer.sv
hdl/link_serializer.sv
hdl/hub_arbiter.sv
hdl/hub_router.sv
hdl/hub_top.sv
tb/hub_tb.sv

// ==== tb/hub_stim.mem ====
// columns: source port (0 down0, 1 down1, 2 up), message, expected route mask
// message is dest_fpga, fifo_id, payload; mask bit 0 down0, bit 1 down1, bit 2 up
2 31000a01 1
2 92000a02 2
2 03000a03 4
2 5f000c04 3
0 2f000c05 4
1 af000c06 4
0 c4000b07 2
1 75000b08 1
0 06000b09 4
1 f7000b0a 2
2 80000a0b 2
1 18000b0c 1
